// ==== src/matmul_pkg.sv ====
package matmul_pkg;

  ////////////////////////////////////////
  // sizes
  ////////////////////////////////////////

  localparam int DATA_W = 8;
  localparam int N = 4;
  localparam int ADDR_W = 2;

  // saturation bounds for a product cut down to one element
  localparam int ELEM_MAX = 2 ** (DATA_W - 1) - 1;
  localparam int ELEM_MIN = -(2 ** (DATA_W - 1));

  ////////////////////////////////////////
  // cycle constants
  ////////////////////////////////////////

  localparam int FEED_CYCLES = 4;
  localparam int MAC_CYCLES = 3;
  localparam int DRAIN_CYCLES = 4;

  // last feed, skew, corner propagation, mac, then one more
  localparam int LATCH_CYCLE = (FEED_CYCLES - 1) + (N - 1) + (N - 1) + MAC_CYCLES + 1;

  // run and drain share one counter
  localparam int CNT_W = $clog2(LATCH_CYCLE + DRAIN_CYCLES + 1);

  ////////////////////////////////////////
  // types
  ////////////////////////////////////////

  typedef logic signed [DATA_W-1:0] elem_t;
  typedef logic [CNT_W-1:0] cnt_t;

  // lane view of a vector, index i is lane i
  typedef elem_t [N-1:0] lane_arr_t;

  // lane 0 sits in the low byte
  typedef struct packed {
    elem_t lane3;
    elem_t lane2;
    elem_t lane1;
    elem_t lane0;
  } vec_t;

  typedef enum logic [2:0] {
    IDLE,
    CLEAR,
    RUN,
    DRAIN,
    ACK
  } ctrl_state_t;

  typedef struct packed {
    logic feed_en;
    logic latch_en;
    logic drain_en;
  } phase_t;

  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] col;
    vec_t              data;
  } result_t;

endpackage

// ==== src/matmul_ctrl.sv ====
`timescale 1ns/1ps

module matmul_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic i_req,
  input  logic i_run_done,
  input  logic i_drain_done,
  output logic o_clear,
  output logic o_run,
  output logic o_drain,
  output logic o_ack
);

  matmul_pkg::ctrl_state_t state;
  matmul_pkg::ctrl_state_t state_nxt;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= matmul_pkg::IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // four-phase handshake around one run
  always_comb begin
    state_nxt = state;
    case (state)
      matmul_pkg::IDLE: begin
        if (i_req) begin
          state_nxt = matmul_pkg::CLEAR;
        end
      end
      matmul_pkg::CLEAR: begin
        state_nxt = matmul_pkg::RUN;
      end
      matmul_pkg::RUN: begin
        if (i_run_done) begin
          state_nxt = matmul_pkg::DRAIN;
        end
      end
      matmul_pkg::DRAIN: begin
        if (i_drain_done) begin
          state_nxt = matmul_pkg::ACK;
        end
      end
      matmul_pkg::ACK: begin
        // hold ack until the requester lets go
        if (!i_req) begin
          state_nxt = matmul_pkg::IDLE;
        end
      end
      default: begin
        state_nxt = matmul_pkg::IDLE;
      end
    endcase
  end

  assign o_clear = (state == matmul_pkg::CLEAR);
  assign o_run = (state == matmul_pkg::RUN);
  assign o_drain = (state == matmul_pkg::DRAIN);
  assign o_ack = (state == matmul_pkg::ACK);

  a_ack_needs_req: assert property (@(posedge clk) disable iff (reset)
    $rose(o_ack) |-> i_req);

endmodule

// ==== src/cycle_counter.sv ====
`timescale 1ns/1ps

module cycle_counter (
  input  logic                clk,
  input  logic                reset,
  input  logic                i_run,
  input  logic                i_drain,
  output matmul_pkg::phase_t  o_phase,
  output logic                o_run_done,
  output logic                o_drain_done
);

  matmul_pkg::cnt_t cnt;

  // counts on through run and drain, back to zero when idle
  always_ff @(posedge clk) begin
    if (reset || !(i_run || i_drain)) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  ////////////////////////////////////////
  // phase decode
  ////////////////////////////////////////

  assign o_phase.feed_en = i_run && (cnt < matmul_pkg::cnt_t'(matmul_pkg::FEED_CYCLES));

  // every accumulator is final here, so the run ends with the latch
  assign o_run_done = i_run && (cnt == matmul_pkg::cnt_t'(matmul_pkg::LATCH_CYCLE));
  assign o_phase.latch_en = o_run_done;

  assign o_phase.drain_en = i_drain;

  assign o_drain_done = i_drain &&
    (cnt == matmul_pkg::cnt_t'(matmul_pkg::LATCH_CYCLE + matmul_pkg::DRAIN_CYCLES));

  a_one_latch_per_run: assert property (@(posedge clk) disable iff (reset)
    $rose(i_run) |-> !o_phase.latch_en [* matmul_pkg::LATCH_CYCLE]
                     ##1 o_phase.latch_en ##1 !o_phase.latch_en);

endmodule

// ==== src/operand_feeder.sv ====
`timescale 1ns/1ps

module operand_feeder (
  input  logic                          clk,
  input  logic                          reset,
  input  matmul_pkg::phase_t            i_phase,
  input  matmul_pkg::vec_t              i_a_col,
  input  matmul_pkg::vec_t              i_b_row,
  output logic [matmul_pkg::ADDR_W-1:0] o_op_addr,
  output matmul_pkg::vec_t              o_a_edge,
  output matmul_pkg::vec_t              o_b_edge
);

  logic [matmul_pkg::ADDR_W-1:0] addr;
  matmul_pkg::lane_arr_t a_in;
  matmul_pkg::lane_arr_t b_in;
  matmul_pkg::lane_arr_t a_lanes;
  matmul_pkg::lane_arr_t b_lanes;

  // one counter serves both operands, wraps back to 0 after k = 3
  always_ff @(posedge clk) begin
    if (reset) begin
      addr <= '0;
    end else if (i_phase.feed_en) begin
      addr <= addr + 1'b1;
    end
  end

  assign o_op_addr = addr;

  // zeros outside the feed window
  assign a_in = i_phase.feed_en ? matmul_pkg::lane_arr_t'(i_a_col) : '0;
  assign b_in = i_phase.feed_en ? matmul_pkg::lane_arr_t'(i_b_row) : '0;

  ////////////////////////////////////////
  // triangular skew
  ////////////////////////////////////////

  for (genvar i = 0; i < matmul_pkg::N; i++) begin : g_lane
    if (i == 0) begin : g_direct
      assign a_lanes[i] = a_in[i];
      assign b_lanes[i] = b_in[i];
    end else begin : g_delay
      matmul_pkg::elem_t a_pipe [i];
      matmul_pkg::elem_t b_pipe [i];

      // lane i waits i cycles
      always_ff @(posedge clk) begin
        a_pipe[0] <= a_in[i];
        b_pipe[0] <= b_in[i];
        for (int s = 1; s < i; s++) begin
          a_pipe[s] <= a_pipe[s-1];
          b_pipe[s] <= b_pipe[s-1];
        end
      end

      assign a_lanes[i] = a_pipe[i-1];
      assign b_lanes[i] = b_pipe[i-1];
    end
  end

  assign o_a_edge = matmul_pkg::vec_t'(a_lanes);
  assign o_b_edge = matmul_pkg::vec_t'(b_lanes);

endmodule

// ==== src/processing_element.sv ====
`timescale 1ns/1ps

module processing_element (
  input  logic              clk,
  input  logic              i_clear,
  input  matmul_pkg::elem_t i_a,
  input  matmul_pkg::elem_t i_b,
  output matmul_pkg::elem_t o_a,
  output matmul_pkg::elem_t o_b,
  output matmul_pkg::elem_t o_acc
);

  matmul_pkg::elem_t a_q;
  matmul_pkg::elem_t b_q;
  logic signed [2*matmul_pkg::DATA_W-1:0] prod_q;
  matmul_pkg::elem_t prod_sat;
  matmul_pkg::elem_t acc_q;

  ////////////////////////////////////////
  // operand stage and product
  ////////////////////////////////////////

  // the pass-through flops are also the first mac stage
  always_ff @(posedge clk) begin
    if (i_clear) begin
      a_q <= '0;
      b_q <= '0;
      prod_q <= '0;
    end else begin
      a_q <= i_a;
      b_q <= i_b;
      prod_q <= a_q * b_q;
    end
  end

  assign o_a = a_q;
  assign o_b = b_q;

  // clamp the 16-bit product into one signed element
  always_comb begin
    if (prod_q > matmul_pkg::ELEM_MAX) begin
      prod_sat = matmul_pkg::elem_t'(matmul_pkg::ELEM_MAX);
    end else if (prod_q < matmul_pkg::ELEM_MIN) begin
      prod_sat = matmul_pkg::elem_t'(matmul_pkg::ELEM_MIN);
    end else begin
      prod_sat = prod_q[matmul_pkg::DATA_W-1:0];
    end
  end

  ////////////////////////////////////////
  // accumulate
  ////////////////////////////////////////

  // plain 8-bit add, overflow wraps
  always_ff @(posedge clk) begin
    if (i_clear) begin
      acc_q <= '0;
    end else begin
      acc_q <= acc_q + prod_sat;
    end
  end

  assign o_acc = acc_q;

endmodule

// ==== src/systolic_array.sv ====
`timescale 1ns/1ps

module systolic_array (
  input  logic             clk,
  input  logic             i_clear,
  input  matmul_pkg::vec_t i_a_edge,
  input  matmul_pkg::vec_t i_b_edge,
  output matmul_pkg::vec_t o_acc_rows [matmul_pkg::N]
);

  // a moves right along a row, b moves down a column
  matmul_pkg::elem_t a_h [matmul_pkg::N][matmul_pkg::N+1];
  matmul_pkg::elem_t b_v [matmul_pkg::N+1][matmul_pkg::N];
  matmul_pkg::lane_arr_t a_lanes;
  matmul_pkg::lane_arr_t b_lanes;
  matmul_pkg::lane_arr_t acc_grid [matmul_pkg::N];

  assign a_lanes = matmul_pkg::lane_arr_t'(i_a_edge);
  assign b_lanes = matmul_pkg::lane_arr_t'(i_b_edge);

  for (genvar i = 0; i < matmul_pkg::N; i++) begin : g_edge
    assign a_h[i][0] = a_lanes[i];
    assign b_v[0][i] = b_lanes[i];
  end

  ////////////////////////////////////////
  // grid
  ////////////////////////////////////////

  for (genvar i = 0; i < matmul_pkg::N; i++) begin : g_row
    for (genvar j = 0; j < matmul_pkg::N; j++) begin : g_col
      // cell (i, j) ends up holding C[i][j]
      processing_element u_pe (
        .clk     (clk),
        .i_clear (i_clear),
        .i_a     (a_h[i][j]),
        .i_b     (b_v[i][j]),
        .o_a     (a_h[i][j+1]),
        .o_b     (b_v[i+1][j]),
        .o_acc   (acc_grid[i][j])
      );
    end

    assign o_acc_rows[i] = matmul_pkg::vec_t'(acc_grid[i]);
  end

endmodule

// ==== src/result_drain.sv ====
`timescale 1ns/1ps

module result_drain (
  input  logic                clk,
  input  logic                reset,
  input  matmul_pkg::phase_t  i_phase,
  input  matmul_pkg::vec_t    i_acc_rows [matmul_pkg::N],
  output matmul_pkg::result_t o_result
);

  matmul_pkg::lane_arr_t rows [matmul_pkg::N];
  matmul_pkg::lane_arr_t col_q [matmul_pkg::N];
  logic [matmul_pkg::ADDR_W-1:0] col_idx;

  for (genvar i = 0; i < matmul_pkg::N; i++) begin : g_rows
    assign rows[i] = matmul_pkg::lane_arr_t'(i_acc_rows[i]);
  end

  ////////////////////////////////////////
  // capture and shift
  ////////////////////////////////////////

  // store transposed so col_q[j] lane i is C[i][j]
  always_ff @(posedge clk) begin
    if (i_phase.latch_en) begin
      for (int j = 0; j < matmul_pkg::N; j++) begin
        for (int i = 0; i < matmul_pkg::N; i++) begin
          col_q[j][i] <= rows[i][j];
        end
      end
    end else if (i_phase.drain_en) begin
      for (int j = 0; j < matmul_pkg::N - 1; j++) begin
        col_q[j] <= col_q[j+1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset || i_phase.latch_en) begin
      col_idx <= '0;
    end else if (i_phase.drain_en) begin
      col_idx <= col_idx + 1'b1;
    end
  end

  // head of the shift register is the current column
  assign o_result.valid = i_phase.drain_en;
  assign o_result.col = col_idx;
  assign o_result.data = matmul_pkg::vec_t'(col_q[0]);

  a_valid_after_latch: assert property (@(posedge clk) disable iff (reset)
    $rose(o_result.valid) |-> $past(i_phase.latch_en));

endmodule

// ==== src/matmul_top.sv ====
`timescale 1ns/1ps

module matmul_top (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          i_req,
  input  matmul_pkg::vec_t              i_a_col,
  input  matmul_pkg::vec_t              i_b_row,
  output logic [matmul_pkg::ADDR_W-1:0] o_op_addr,
  output matmul_pkg::result_t           o_result,
  output logic                          o_ack
);

  logic clear;
  logic run;
  logic drain;
  logic run_done;
  logic drain_done;
  matmul_pkg::phase_t phase;
  matmul_pkg::vec_t a_edge;
  matmul_pkg::vec_t b_edge;
  matmul_pkg::vec_t acc_rows [matmul_pkg::N];

  ////////////////////////////////////////
  // control
  ////////////////////////////////////////

  matmul_ctrl u_ctrl (
    .clk          (clk),
    .reset        (reset),
    .i_req        (i_req),
    .i_run_done   (run_done),
    .i_drain_done (drain_done),
    .o_clear      (clear),
    .o_run        (run),
    .o_drain      (drain),
    .o_ack        (o_ack)
  );

  cycle_counter u_counter (
    .clk          (clk),
    .reset        (reset),
    .i_run        (run),
    .i_drain      (drain),
    .o_phase      (phase),
    .o_run_done   (run_done),
    .o_drain_done (drain_done)
  );

  ////////////////////////////////////////
  // datapath
  ////////////////////////////////////////

  operand_feeder u_feeder (
    .clk       (clk),
    .reset     (reset),
    .i_phase   (phase),
    .i_a_col   (i_a_col),
    .i_b_row   (i_b_row),
    .o_op_addr (o_op_addr),
    .o_a_edge  (a_edge),
    .o_b_edge  (b_edge)
  );

  systolic_array u_array (
    .clk        (clk),
    .i_clear    (clear),
    .i_a_edge   (a_edge),
    .i_b_edge   (b_edge),
    .o_acc_rows (acc_rows)
  );

  result_drain u_drain (
    .clk        (clk),
    .reset      (reset),
    .i_phase    (phase),
    .i_acc_rows (acc_rows),
    .o_result   (o_result)
  );

endmodule

// ==== bench/tb_matmul.sv ====
`timescale 1ns/1ps

module tb_matmul;

  localparam int NUM_FIXED = 3;
  localparam int NUM_RANDOM = 8;
  localparam int NUM_TESTS = NUM_FIXED + NUM_RANDOM;
  localparam int WORDS_PER_TEST = 12;
  localparam int PATTERN_WORDS = NUM_FIXED * WORDS_PER_TEST;
  localparam int CYCLE_LIMIT = 40 * NUM_TESTS;

  logic clk;
  logic reset;
  logic i_req;
  matmul_pkg::vec_t i_a_col;
  matmul_pkg::vec_t i_b_row;
  logic [matmul_pkg::ADDR_W-1:0] o_op_addr;
  matmul_pkg::result_t o_result;
  logic o_ack;

  logic [31:0] patterns [PATTERN_WORDS];
  logic [31:0] a_cols [matmul_pkg::N];
  logic [31:0] b_rows [matmul_pkg::N];
  logic [31:0] exp_cols [matmul_pkg::N];
  int errors;
  int checks;
  int cycles;
  int seed;

  matmul_top dut (
    .clk       (clk),
    .reset     (reset),
    .i_req     (i_req),
    .i_a_col   (i_a_col),
    .i_b_row   (i_b_row),
    .o_op_addr (o_op_addr),
    .o_result  (o_result),
    .o_ack     (o_ack)
  );

  // operand memory answers in the same cycle
  assign i_a_col = matmul_pkg::vec_t'(a_cols[o_op_addr]);
  assign i_b_row = matmul_pkg::vec_t'(b_rows[o_op_addr]);

  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  // run limit
  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Result: FAILED");
    $finish;
  end

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  function automatic logic signed [7:0] lane_of(logic [31:0] word, int lane);
    return word[8*lane +: 8];
  endfunction

  // product cut to the signed 8-bit range
  function automatic logic signed [7:0] clamp_product(int p);
    if (p > 127) begin
      return 8'h7f;
    end else if (p < -128) begin
      return 8'h80;
    end
    return p[7:0];
  endfunction

  task automatic compute_reference();
    int av;
    int bv;
    int sum;
    for (int j = 0; j < matmul_pkg::N; j++) begin
      for (int i = 0; i < matmul_pkg::N; i++) begin
        sum = 0;
        for (int k = 0; k < matmul_pkg::N; k++) begin
          av = lane_of(a_cols[k], i);
          bv = lane_of(b_rows[k], j);
          sum = sum + clamp_product(av * bv);
        end
        // low byte is the sum modulo 256
        exp_cols[j][8*i +: 8] = sum[7:0];
      end
    end
  endtask

  ////////////////////////////////////////
  // stimulus and checks
  ////////////////////////////////////////

  // background for the pattern memory before the file is read
  function automatic logic [31:0] fill_word(int w);
    return 32'hc35a_96e1 ^ w;
  endfunction

  task automatic load_fixed(input int t);
    for (int k = 0; k < matmul_pkg::N; k++) begin
      a_cols[k] = patterns[t*WORDS_PER_TEST + k];
      b_rows[k] = patterns[t*WORDS_PER_TEST + 4 + k];
      exp_cols[k] = patterns[t*WORDS_PER_TEST + 8 + k];
    end
  endtask

  task automatic load_random();
    for (int k = 0; k < matmul_pkg::N; k++) begin
      a_cols[k] = $random(seed);
      b_rows[k] = $random(seed);
    end
    compute_reference();
  endtask

  task automatic check_idle(input int n);
    repeat (n) begin
      @(negedge clk);
      checks++;
      if (o_ack !== 1'b0 || o_result.valid !== 1'b0) begin
        errors++;
        $display("ERR %0t: ack=%b valid=%b while idle", $time, o_ack, o_result.valid);
      end
    end
  endtask

  task automatic check_word(input int t, input int idx);
    logic [31:0] got;
    got = o_result.data;
    checks++;
    if (idx >= matmul_pkg::N) begin
      errors++;
      $display("ERR %0t: test %0d extra valid word %h", $time, t, got);
    end else begin
      if (o_result.col !== idx[1:0]) begin
        errors++;
        $display("ERR %0t: test %0d column index %0d, expected %0d",
                 $time, t, o_result.col, idx);
      end
      if (got !== exp_cols[idx]) begin
        errors++;
        $display("ERR %0t: test %0d column %0d is %h, expected %h",
                 $time, t, idx, got, exp_cols[idx]);
      end
    end
  endtask

  // one four-phase handshake entered on a falling edge
  task automatic run_request(input int t);
    int words;
    int cyc;
    words = 0;
    cyc = 0;
    i_req = 1'b1;
    @(negedge clk);
    while (o_ack !== 1'b1) begin
      // run cycle k follows CLEAR and reads operand k
      if (cyc >= 1 && cyc <= matmul_pkg::FEED_CYCLES) begin
        checks++;
        if (o_op_addr !== cyc - 1) begin
          errors++;
          $display("ERR %0t: test %0d operand address %0d, expected %0d",
                   $time, t, o_op_addr, cyc - 1);
        end
      end
      if (o_result.valid === 1'b1) begin
        check_word(t, words);
        words++;
      end
      cyc++;
      @(negedge clk);
    end
    checks++;
    if (words != matmul_pkg::N) begin
      errors++;
      $display("ERR %0t: test %0d ack after %0d words", $time, t, words);
    end
    // ack holds as long as req does
    repeat (2) begin
      @(negedge clk);
      checks++;
      if (o_ack !== 1'b1 || o_result.valid !== 1'b0) begin
        errors++;
        $display("ERR %0t: test %0d ack=%b valid=%b with req held",
                 $time, t, o_ack, o_result.valid);
      end
    end
    i_req = 1'b0;
    @(negedge clk);
    checks++;
    if (o_ack !== 1'b0) begin
      errors++;
      $display("ERR %0t: test %0d ack still high after req fell", $time, t);
    end
  endtask

  initial begin
    reset = 1'b1;
    i_req = 1'b0;
    errors = 0;
    checks = 0;
    seed = 32'h393f_81a2;
    for (int k = 0; k < matmul_pkg::N; k++) begin
      a_cols[k] = '0;
      b_rows[k] = '0;
      exp_cols[k] = '0;
    end
    for (int w = 0; w < PATTERN_WORDS; w++) begin
      patterns[w] = fill_word(w);
    end
    $readmemh("bench/matmul_patterns.txt", patterns);
    if (patterns[PATTERN_WORDS-1] === fill_word(PATTERN_WORDS - 1)) begin
      errors++;
      $display("the pattern file bench/matmul_patterns.txt could not be read in full");
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    check_idle(3);

    for (int t = 0; t < NUM_TESTS; t++) begin
      if (t < NUM_FIXED) begin
        load_fixed(t);
      end else begin
        load_random();
      end
      run_request(t);
      check_idle(2);
    end

    $display("checks: %0d errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== bench/matmul_patterns.txt ====
// each test is three lines: A columns k = 0..3, B rows k = 0..3, expected C columns j = 0..3
// a word holds lane 3 in the high byte down to lane 0 in the low byte
// test 0: B is the identity, so C repeats A
FFF00501 00100602 117F0703 22800804
00000001 00000100 00010000 01000000
FFF00501 00100602 117F0703 22800804
// test 1: saturated products, then the accumulation wraps
807F807F 7F00807F 0000807F 0000807F
807FFF7F 807FFF7F 807FFF7F 807FFF7F
FF7F00FC 0081FC04 FF7F00FC FF80FC00
// test 2: small mixed-sign values, no saturation
0205FF01 02FE0002 FC010203 0100FD04
03FE0001 FF000102 02010300 000402FF
05010201 F8010013 FCF7F811 FC130107

// ==== verilog.f ====
src/matmul_pkg.sv
src/matmul_ctrl.sv
src/cycle_counter.sv
src/operand_feeder.sv
src/processing_element.sv
src/systolic_array.sv
src/result_drain.sv
src/matmul_top.sv
bench/tb_matmul.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the matmul testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_matmul -f verilog.f

./obj_dir/Vtb_matmul | tee sim.log

if grep -q "^Result: PASSED$" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
